//--- Bender.yml
package:
  name: cpu_core

sources:
  # RTL, package first
  - files:
      - source/cpu_pkg.sv
      - source/cpu_alu.sv
      - source/int_mul.sv
      - source/reg_file.sv
      - source/cpu_control.sv
      - source/cpu_core.sv

  # testbench and bound assertions
  - target: test
    files:
      - tb/cpu_assert.sv
      - tb/tb_cpu.sv

//--- source/cpu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
  input  wire [cpu_pkg::data_w-1:0]  in1,
  input  wire [cpu_pkg::data_w-1:0]  in2,
  input  wire cpu_pkg::alu_func_t    func,
  output logic [cpu_pkg::data_w-1:0] result,
  output cpu_pkg::ccr_t              flags
);

  logic [cpu_pkg::data_w:0] wide;  // top bit is carry out
  logic                     overflow;

  always_comb begin
    wide     = '0;
    overflow = 1'b0;
    case (func)
      cpu_pkg::alu_add: begin
        wide     = {1'b0, in1} + {1'b0, in2};
        overflow = (in1[31] == in2[31]) && (wide[31] != in1[31]);
      end
      cpu_pkg::alu_sub: begin
        wide     = {1'b0, in1} - {1'b0, in2};  // wraps to 1 on borrow
        overflow = (in1[31] != in2[31]) && (wide[31] != in1[31]);
      end
      cpu_pkg::alu_and: wide = {1'b0, in1 & in2};
      cpu_pkg::alu_or:  wide = {1'b0, in1 | in2};
      cpu_pkg::alu_xor: wide = {1'b0, in1 ^ in2};
      cpu_pkg::alu_shl: wide = {1'b0, in1 << in2[4:0]};
      cpu_pkg::alu_shr: wide = {1'b0, in1 >> in2[4:0]};
      cpu_pkg::alu_sar: wide = {1'b0, $signed(in1) >>> in2[4:0]};
      default:          wide = '0;
    endcase
  end

  assign result = wide[cpu_pkg::data_w-1:0];

  // logic ops and shifts never set the top bit, so carry is zero there
  assign flags.carry = wide[cpu_pkg::data_w];
  assign flags.lt    = wide[31] ^ overflow;
  assign flags.zero  = (result == '0);

endmodule

`default_nettype wire

//--- source/cpu_control.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_control (
  input  wire                  clk,
  input  wire                  reset_n,
  input  wire cpu_pkg::instr_t ir,
  input  wire cpu_pkg::ccr_t   ccr,
  input  wire [1:0]            bus_align,
  input  wire                  waitrequest,
  output cpu_pkg::ctl_t        ctl,
  output logic                 read,
  output logic                 write,
  output logic                 halt,
  output logic [3:0]           byteenable
);

  cpu_pkg::ctl_state_t state;
  cpu_pkg::ctl_state_t state_next;
  logic is_load;
  logic is_store;
  logic is_byte;
  logic is_mul;
  logic taken;
  logic bus_done;

  assign is_load  = (ir.op == cpu_pkg::op_ld) || (ir.op == cpu_pkg::op_ldb);
  assign is_store = (ir.op == cpu_pkg::op_st) || (ir.op == cpu_pkg::op_stb);
  assign is_byte  = (ir.op == cpu_pkg::op_ldb) || (ir.op == cpu_pkg::op_stb);
  assign is_mul   = (ir.op == cpu_pkg::op_mul) || (ir.op == cpu_pkg::op_mulh) ||
                    (ir.op == cpu_pkg::op_mulhu);
  assign bus_done = (read | write) & ~waitrequest;  // transfer completes this cycle

  always_comb begin
    case (cpu_pkg::cond_t'(ir.ra))
      cpu_pkg::cond_always: taken = 1'b1;
      cpu_pkg::cond_eq:     taken = ccr.zero;
      cpu_pkg::cond_ne:     taken = ~ccr.zero;
      cpu_pkg::cond_lt:     taken = ccr.lt;
      cpu_pkg::cond_ltu:    taken = ccr.carry;
      default:              taken = 1'b0;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      cpu_pkg::st_fetch: begin
        if (bus_done) begin
          state_next = cpu_pkg::st_decode;
        end
      end
      cpu_pkg::st_decode: begin
        if (ir.op == cpu_pkg::op_halt) begin
          state_next = cpu_pkg::st_halt;
        end else begin
          state_next = cpu_pkg::st_exec;
        end
      end
      cpu_pkg::st_exec: begin
        if (is_load || is_store) begin
          state_next = cpu_pkg::st_mem;
        end else if (is_mul) begin
          state_next = cpu_pkg::st_wb;  // wait on the product register
        end else begin
          state_next = cpu_pkg::st_fetch;
        end
      end
      cpu_pkg::st_mem: begin
        if (bus_done) begin
          state_next = cpu_pkg::st_wb;
        end
      end
      cpu_pkg::st_wb:   state_next = cpu_pkg::st_fetch;
      cpu_pkg::st_halt: state_next = cpu_pkg::st_halt;
      default:          state_next = cpu_pkg::st_fetch;
    endcase
  end

  // strobes follow the next state so they rise on entry
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= cpu_pkg::st_fetch;
      read  <= 1'b0;
      write <= 1'b0;
      halt  <= 1'b0;
    end else begin
      state <= state_next;
      read  <= (state_next == cpu_pkg::st_fetch) ||
               ((state_next == cpu_pkg::st_mem) && is_load);
      write <= (state_next == cpu_pkg::st_mem) && is_store;
      halt  <= (state_next == cpu_pkg::st_halt);
    end
  end

  assign byteenable = (state == cpu_pkg::st_mem && is_byte) ? 4'b0001 << bus_align : 4'b1111;

  always_comb begin
    ctl.pc_sel  = cpu_pkg::pc_hold;
    ctl.mar_sel = cpu_pkg::mar_hold;
    ctl.mdr_sel = cpu_pkg::mdr_hold;
    ctl.reg_sel = cpu_pkg::reg_alu;
    if (ir.op == cpu_pkg::op_alu) begin
      ctl.alu2_sel = cpu_pkg::alu2_reg;
      ctl.alu_func = cpu_pkg::alu_func_t'(ir.imm[2:0]);
    end else begin
      ctl.alu2_sel = cpu_pkg::alu2_imm;  // addi and address offsets
      ctl.alu_func = cpu_pkg::alu_add;
    end
    ctl.mul_signed = (ir.op != cpu_pkg::op_mulhu);
    ctl.rd_addr1   = ir.rb;
    ctl.rd_addr2   = is_store ? ir.ra : ir.rc;
    ctl.wr_addr    = ir.ra;
    ctl.reg_write  = 1'b0;
    ctl.ir_write   = 1'b0;
    ctl.ccr_write  = 1'b0;
    ctl.addrsel    = (state == cpu_pkg::st_mem);
    case (state)
      cpu_pkg::st_fetch: begin
        if (bus_done) begin
          ctl.ir_write = 1'b1;
          ctl.pc_sel   = cpu_pkg::pc_inc;
        end
      end
      cpu_pkg::st_exec: begin
        case (ir.op)
          cpu_pkg::op_alu, cpu_pkg::op_addi: begin
            ctl.reg_write = 1'b1;
            ctl.ccr_write = 1'b1;
          end
          cpu_pkg::op_ldi: begin
            ctl.reg_write = 1'b1;
            ctl.reg_sel   = cpu_pkg::reg_imm;
          end
          cpu_pkg::op_br: begin
            if (taken) begin
              ctl.pc_sel = cpu_pkg::pc_rel;
            end
          end
          cpu_pkg::op_ld, cpu_pkg::op_ldb: ctl.mar_sel = cpu_pkg::mar_alu;
          cpu_pkg::op_st, cpu_pkg::op_stb: begin
            ctl.mar_sel = cpu_pkg::mar_alu;
            ctl.mdr_sel = cpu_pkg::mdr_reg;  // store data from ra
          end
          default: ctl.pc_sel = cpu_pkg::pc_hold;
        endcase
      end
      cpu_pkg::st_mem: begin
        if (is_load && bus_done) begin
          ctl.mdr_sel = cpu_pkg::mdr_bus;
        end
      end
      cpu_pkg::st_wb: begin
        ctl.reg_write = is_load || is_mul;
        case (ir.op)
          cpu_pkg::op_mul:                    ctl.reg_sel = cpu_pkg::reg_prod_lo;
          cpu_pkg::op_mulh, cpu_pkg::op_mulhu: ctl.reg_sel = cpu_pkg::reg_prod_hi;
          default:                            ctl.reg_sel = cpu_pkg::reg_mdr;
        endcase
      end
      default: ctl.ir_write = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
  input  wire         clk,
  input  wire         reset_n,
  output logic [31:0] address,
  output logic        read,
  output logic        write,
  input  wire         waitrequest,
  input  wire  [31:0] readdata,
  output logic [31:0] writedata,
  output logic [3:0]  byteenable,
  output logic        halt
);

  cpu_pkg::ctl_t   ctl;
  cpu_pkg::instr_t ir;
  cpu_pkg::ccr_t   ccr;
  cpu_pkg::ccr_t   alu_flags;

  logic [31:0] pc;
  logic [31:0] pc_next;
  logic [31:0] mar;
  logic [31:0] mar_next;
  logic [31:0] mdr;
  logic [31:0] mdr_next;
  logic [31:0] aluval;
  logic [31:0] alu_out;
  logic [31:0] alu_in2;
  logic [31:0] reg_data1;
  logic [31:0] reg_data2;
  logic [31:0] reg_wdata;
  logic [31:0] imm_sext;
  logic [31:0] busin;     // load data, byte already moved to lane 0
  logic [63:0] product;

  assign imm_sext = {{16{ir.imm[15]}}, ir.imm};
  assign address  = ctl.addrsel ? mar : pc;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc  <= cpu_pkg::reset_pc;
      ir  <= '0;
      ccr <= '0;
    end else begin
      pc <= pc_next;
      if (ctl.ir_write) begin
        ir <= cpu_pkg::instr_t'(readdata);
      end
      if (ctl.ccr_write) begin
        ccr <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    mar    <= mar_next;
    mdr    <= mdr_next;
    aluval <= alu_out;
  end

  always_comb begin
    case (ctl.pc_sel)
      cpu_pkg::pc_inc: pc_next = pc + 32'd4;
      cpu_pkg::pc_rel: pc_next = pc + imm_sext;  // pc already past the branch
      default:         pc_next = pc;
    endcase
    mar_next = (ctl.mar_sel == cpu_pkg::mar_alu) ? aluval : mar;
    case (ctl.mdr_sel)
      cpu_pkg::mdr_bus: mdr_next = busin;
      cpu_pkg::mdr_reg: mdr_next = reg_data2;
      cpu_pkg::mdr_pc:  mdr_next = pc;
      default:          mdr_next = mdr;
    endcase
    case (ctl.reg_sel)
      cpu_pkg::reg_mdr:     reg_wdata = mdr;
      cpu_pkg::reg_imm:     reg_wdata = imm_sext;
      cpu_pkg::reg_prod_lo: reg_wdata = product[31:0];
      cpu_pkg::reg_prod_hi: reg_wdata = product[63:32];
      default:              reg_wdata = aluval;
    endcase
    alu_in2 = (ctl.alu2_sel == cpu_pkg::alu2_imm) ? imm_sext : reg_data2;
  end

  // byte lanes follow byteenable
  always_comb begin
    case (byteenable)
      4'b0001: begin
        writedata = {24'h0, mdr[7:0]};
        busin     = {24'h0, readdata[7:0]};
      end
      4'b0010: begin
        writedata = {16'h0, mdr[7:0], 8'h0};
        busin     = {24'h0, readdata[15:8]};
      end
      4'b0100: begin
        writedata = {8'h0, mdr[7:0], 16'h0};
        busin     = {24'h0, readdata[23:16]};
      end
      4'b1000: begin
        writedata = {mdr[7:0], 24'h0};
        busin     = {24'h0, readdata[31:24]};
      end
      default: begin
        writedata = mdr;
        busin     = readdata;
      end
    endcase
  end

  cpu_control u_control (
    .clk         (clk),
    .reset_n     (reset_n),
    .ir          (ir),
    .ccr         (ccr),
    .bus_align   (address[1:0]),
    .waitrequest (waitrequest),
    .ctl         (ctl),
    .read        (read),
    .write       (write),
    .halt        (halt),
    .byteenable  (byteenable)
  );

  cpu_alu u_alu (
    .in1    (reg_data1),
    .in2    (alu_in2),
    .func   (ctl.alu_func),
    .result (alu_out),
    .flags  (alu_flags)
  );

  int_mul u_mul (
    .clk       (clk),
    .reset_n   (reset_n),
    .in1       (reg_data1),
    .in2       (reg_data2),
    .is_signed (ctl.mul_signed),
    .product   (product)
  );

  reg_file u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .read_addr1 (ctl.rd_addr1),
    .read_addr2 (ctl.rd_addr2),
    .write_addr (ctl.wr_addr),
    .write_data (reg_wdata),
    .write_en   (ctl.reg_write),
    .data1      (reg_data1),
    .data2      (reg_data2)
  );

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int data_w = 32;
  localparam logic [data_w-1:0] reset_pc = '0;

  typedef enum logic [3:0] {
    op_nop   = 4'h0,
    op_alu   = 4'h1,
    op_addi  = 4'h2,
    op_ldi   = 4'h3,
    op_mul   = 4'h4,
    op_mulh  = 4'h5,
    op_mulhu = 4'h6,
    op_ld    = 4'h7,
    op_ldb   = 4'h8,
    op_st    = 4'h9,
    op_stb   = 4'ha,
    op_br    = 4'hb,
    op_halt  = 4'hc
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr, alu_sar
  } alu_func_t;

  // branch condition, carried in the ra field
  typedef enum logic [3:0] {
    cond_always, cond_eq, cond_ne, cond_lt, cond_ltu
  } cond_t;

  typedef struct packed {
    opcode_t     op;
    logic [3:0]  ra;  // dest, store data or branch cond
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [15:0] imm; // alu func in low 3 bits for op_alu
  } instr_t;

  typedef struct packed {
    logic carry; // borrow on sub
    logic lt;    // negative ^ overflow
    logic zero;
  } ccr_t;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_exec, st_mem, st_wb, st_halt
  } ctl_state_t;

  typedef enum logic [1:0] {pc_hold, pc_inc, pc_rel} pc_sel_t;
  typedef enum logic [1:0] {mar_hold, mar_alu} mar_sel_t;
  typedef enum logic [1:0] {mdr_hold, mdr_bus, mdr_reg, mdr_pc} mdr_sel_t;
  typedef enum logic [2:0] {reg_alu, reg_mdr, reg_imm, reg_prod_lo, reg_prod_hi} reg_sel_t;
  typedef enum logic [1:0] {alu2_reg, alu2_imm} alu2_sel_t;

  typedef struct packed {
    pc_sel_t    pc_sel;
    mar_sel_t   mar_sel;
    mdr_sel_t   mdr_sel;
    reg_sel_t   reg_sel;
    alu2_sel_t  alu2_sel;
    alu_func_t  alu_func;
    logic       mul_signed;
    logic [3:0] rd_addr1;
    logic [3:0] rd_addr2;
    logic [3:0] wr_addr;
    logic       reg_write;
    logic       ir_write;
    logic       ccr_write;
    logic       addrsel;  // bus address from mar, else pc
  } ctl_t;

endpackage

`default_nettype wire

//--- source/int_mul.sv
`timescale 1ns/10ps
`default_nettype none

module int_mul (
  input  wire         clk,
  input  wire         reset_n,
  input  wire  [31:0] in1,
  input  wire  [31:0] in2,
  input  wire         is_signed,
  output logic [63:0] product
);

  logic signed [32:0] op1;
  logic signed [32:0] op2;
  logic signed [63:0] full;

  // extra top bit lets one signed multiplier serve both modes
  assign op1  = {is_signed & in1[31], in1};
  assign op2  = {is_signed & in2[31], in2};
  assign full = op1 * op2;  // low 64 bits are exact either way

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      product <= '0;
    end else begin
      product <= full;
    end
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire  [3:0]                 read_addr1,
  input  wire  [3:0]                 read_addr2,
  input  wire  [3:0]                 write_addr,
  input  wire  [cpu_pkg::data_w-1:0] write_data,
  input  wire                        write_en,
  output logic [cpu_pkg::data_w-1:0] data1,
  output logic [cpu_pkg::data_w-1:0] data2
);

  logic [cpu_pkg::data_w-1:0] regs [16];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  // reads are combinational, a write shows up after the edge
  assign data1 = regs[read_addr1];
  assign data2 = regs[read_addr2];

endmodule

`default_nettype wire

//--- tb/cpu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_assert (
  input wire        clk,
  input wire        reset_n,
  input wire        read,
  input wire        write,
  input wire        waitrequest,
  input wire        halt,
  input wire [31:0] address,
  input wire [3:0]  byteenable
);

  int failures = 0;  // read back by tb_cpu

  rw_exclusive: assert property (@(posedge clk) disable iff (!reset_n) !(read && write))
    else begin
      $error("read and write high in the same cycle");
      failures++;
    end

  request_held: assert property (@(posedge clk) disable iff (!reset_n)
      (read || write) && waitrequest |=>
      $stable(address) && $stable(byteenable) && $stable(read) && $stable(write))
    else begin
      $error("request changed while waitrequest was high");
      failures++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (!reset_n) halt |=> halt)
    else begin
      $error("halt fell without reset");
      failures++;
    end

  be_legal: assert property (@(posedge clk) disable iff (!reset_n)
      byteenable inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1111})
    else begin
      $error("illegal byteenable %b", byteenable);
      failures++;
    end

  // word accesses aligned, byte lane matches the address
  be_lane: assert property (@(posedge clk) disable iff (!reset_n)
      (read || write) |-> ((byteenable == 4'b1111) ? (address[1:0] == 2'b00) :
                           (byteenable == (4'b0001 << address[1:0]))))
    else begin
      $error("byteenable %b does not match address %h", byteenable, address);
      failures++;
    end

endmodule

bind cpu_core cpu_assert u_assert (
  .clk         (clk),
  .reset_n     (reset_n),
  .read        (read),
  .write       (write),
  .waitrequest (waitrequest),
  .halt        (halt),
  .address     (address),
  .byteenable  (byteenable)
);

`default_nettype wire

//--- tb/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

  localparam int clk_period  = 4;
  localparam int n_programs  = 10;
  localparam int max_instr   = 400;
  localparam int n_random    = 120;
  localparam int mem_words   = 256;  // 1 KiB
  localparam int data_base   = 32'h300;
  localparam int dump_base   = 32'h380;
  localparam int watchdog_ns = n_programs * max_instr * 20 * clk_period;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;  // enabled lanes only
    logic [3:0]  be;
  } store_t;

  logic        clk;
  logic        reset_n;
  logic        waitrequest;
  logic [31:0] readdata;
  wire  [31:0] address;
  wire         read;
  wire         write;
  wire  [31:0] writedata;
  wire  [3:0]  byteenable;
  wire         halt;

  logic [31:0] dut_mem [mem_words];
  logic [31:0] ref_mem [mem_words];
  store_t      expected [$];
  int          code_len;
  int          errors;
  int          executed;

  cpu_core dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .address     (address),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .halt        (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    return (old & ~lane_mask(be)) | (data & lane_mask(be));
  endfunction

  task automatic put_instr(input cpu_pkg::opcode_t op, input logic [3:0] ra,
                           input logic [3:0] rb, input logic [3:0] rc, input logic [15:0] imm);
    cpu_pkg::instr_t ins;
    ins.op  = op;
    ins.ra  = ra;
    ins.rb  = rb;
    ins.rc  = rc;
    ins.imm = imm;
    dut_mem[code_len] = ins;
    code_len++;
  endtask

  task automatic build_program();
    cpu_pkg::opcode_t op;
    logic [7:0]       a8;
    int               dump_at;
    int               kind;
    int               reach;
    dump_at = 16 + n_random;
    for (int i = 0; i < mem_words; i++) begin
      a8 = 8'(i);
      dut_mem[i] = {a8, ~a8, a8 ^ 8'h5a, ~a8 ^ 8'h3c};
    end
    for (int i = data_base / 4; i < dump_base / 4; i++) begin
      dut_mem[i] = $urandom();
    end
    code_len = 0;
    for (int r = 0; r < 15; r++) begin
      put_instr(cpu_pkg::op_ldi, 4'(r), 4'h0, 4'h0, 16'($urandom()));
    end
    put_instr(cpu_pkg::op_ldi, 4'hf, 4'h0, 4'h0, 16'(data_base));  // r15 stays the data base
    while (code_len < dump_at) begin
      kind = $urandom_range(0, 19);
      if (kind < 6) begin
        put_instr(cpu_pkg::op_alu, 4'($urandom_range(0, 14)), 4'($urandom()), 4'($urandom()),
                  16'($urandom_range(0, 7)));
      end else if (kind < 8) begin
        put_instr(cpu_pkg::op_addi, 4'($urandom_range(0, 14)), 4'($urandom()), 4'h0,
                  16'($urandom()));
      end else if (kind == 8) begin
        put_instr(cpu_pkg::op_ldi, 4'($urandom_range(0, 14)), 4'h0, 4'h0, 16'($urandom()));
      end else if (kind < 12) begin
        op = (kind == 9) ? cpu_pkg::op_mul : (kind == 10) ? cpu_pkg::op_mulh : cpu_pkg::op_mulhu;
        put_instr(op, 4'($urandom_range(0, 14)), 4'($urandom()), 4'($urandom()), 16'h0);
      end else if (kind < 16) begin
        op = (kind == 12) ? cpu_pkg::op_ld : (kind == 13) ? cpu_pkg::op_ldb :
             (kind == 14) ? cpu_pkg::op_st : cpu_pkg::op_stb;
        put_instr(op, 4'($urandom_range(0, (kind < 14) ? 14 : 15)), 4'hf, 4'h0,
                  (kind % 2 == 0) ? 16'(4 * $urandom_range(0, 31)) : 16'($urandom_range(0, 127)));
      end else begin
        reach = dump_at - code_len - 1;  // forward only, never past the dump
        if (reach > 4) begin
          reach = 4;
        end
        put_instr(cpu_pkg::op_br, 4'($urandom_range(0, 4)), 4'h0, 4'h0,
                  16'(4 * $urandom_range(0, reach)));
      end
    end
    for (int r = 0; r < 16; r++) begin
      put_instr(cpu_pkg::op_st, 4'(r), 4'hf, 4'h0, 16'(dump_base - data_base + 4 * r));
    end
    put_instr(cpu_pkg::op_halt, 4'h0, 4'h0, 4'h0, 16'h0);
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = dut_mem[i];
    end
  endtask

  task automatic alu_model(input cpu_pkg::alu_func_t func, input logic [31:0] a,
                           input logic [31:0] b, output logic [31:0] res,
                           output cpu_pkg::ccr_t flags);
    logic [32:0] wide;
    flags = '0;
    case (func)
      cpu_pkg::alu_add: begin
        wide        = {1'b0, a} + {1'b0, b};
        res         = wide[31:0];
        flags.carry = wide[32];
        wide        = {a[31], a} + {b[31], b};  // sign of the exact sum
        flags.lt    = wide[32];
      end
      cpu_pkg::alu_sub: begin
        res         = a - b;
        flags.carry = (a < b);
        flags.lt    = ($signed(a) < $signed(b));
      end
      cpu_pkg::alu_and: res = a & b;
      cpu_pkg::alu_or:  res = a | b;
      cpu_pkg::alu_xor: res = a ^ b;
      cpu_pkg::alu_shl: res = a << b[4:0];
      cpu_pkg::alu_shr: res = a >> b[4:0];
      default:          res = $signed(a) >>> b[4:0];
    endcase
    if (func != cpu_pkg::alu_add && func != cpu_pkg::alu_sub) begin
      flags.lt = res[31];  // no overflow outside add and sub
    end
    flags.zero = (res == '0);
  endtask

  // instruction-set model, fills the expected store queue
  task automatic run_model();
    logic [31:0]       r [16];
    logic [31:0]       pc;
    logic [31:0]       next_pc;
    logic [31:0]       addr;
    logic [31:0]       imm_x;
    logic [31:0]       word;
    longint            sa;
    longint            sb;
    longint unsigned   ua;
    longint unsigned   ub;
    longint            sprod;
    longint unsigned   uprod;
    cpu_pkg::instr_t   ins;
    cpu_pkg::ccr_t     ccr;
    store_t            rec;
    logic              taken;
    logic              done;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
    end
    ccr      = '0;
    pc       = '0;
    done     = 1'b0;
    executed = 0;
    while (!done && executed < max_instr) begin
      ins     = cpu_pkg::instr_t'(ref_mem[pc[9:2]]);
      imm_x   = {{16{ins.imm[15]}}, ins.imm};
      addr    = r[ins.rb] + imm_x;
      next_pc = pc + 32'd4;
      sa      = $signed(r[ins.rb]);
      sb      = $signed(r[ins.rc]);
      ua      = r[ins.rb];
      ub      = r[ins.rc];
      sprod   = sa * sb;
      uprod   = ua * ub;
      case (ins.op)
        cpu_pkg::op_alu:   alu_model(cpu_pkg::alu_func_t'(ins.imm[2:0]), r[ins.rb], r[ins.rc],
                                     r[ins.ra], ccr);
        cpu_pkg::op_addi:  alu_model(cpu_pkg::alu_add, r[ins.rb], imm_x, r[ins.ra], ccr);
        cpu_pkg::op_ldi:   r[ins.ra] = imm_x;
        cpu_pkg::op_mul:   r[ins.ra] = sprod[31:0];
        cpu_pkg::op_mulh:  r[ins.ra] = sprod[63:32];
        cpu_pkg::op_mulhu: r[ins.ra] = uprod[63:32];
        cpu_pkg::op_ld:    r[ins.ra] = ref_mem[addr[9:2]];
        cpu_pkg::op_ldb: begin
          word      = ref_mem[addr[9:2]];
          r[ins.ra] = {24'h0, word[8*addr[1:0] +: 8]};
        end
        cpu_pkg::op_st, cpu_pkg::op_stb: begin
          rec.addr = addr;
          rec.be   = (ins.op == cpu_pkg::op_st) ? 4'b1111 : 4'b0001 << addr[1:0];
          rec.data = ((ins.op == cpu_pkg::op_st) ? r[ins.ra] : {4{r[ins.ra][7:0]}}) &
                     lane_mask(rec.be);
          ref_mem[addr[9:2]] = merge_lanes(ref_mem[addr[9:2]], rec.data, rec.be);
          expected.push_back(rec);
        end
        cpu_pkg::op_br: begin
          case (cpu_pkg::cond_t'(ins.ra))
            cpu_pkg::cond_always: taken = 1'b1;
            cpu_pkg::cond_eq:     taken = ccr.zero;
            cpu_pkg::cond_ne:     taken = !ccr.zero;
            cpu_pkg::cond_lt:     taken = ccr.lt;
            cpu_pkg::cond_ltu:    taken = ccr.carry;
            default:              taken = 1'b0;
          endcase
          if (taken) begin
            next_pc = pc + 32'd4 + imm_x;
          end
        end
        cpu_pkg::op_halt: done = 1'b1;
        default: next_pc = pc + 32'd4;
      endcase
      pc = next_pc;
      executed++;
    end
  endtask

  // called on the falling edge, answers whatever request is up
  task automatic serve_bus();
    store_t exp_st;
    logic [31:0] mask;
    if (!(read || write)) begin
      waitrequest = 1'($urandom_range(0, 1));
    end else if ($urandom_range(0, 3) == 0) begin
      waitrequest = 1'b1;
    end else begin
      waitrequest = 1'b0;  // completes on the next rising edge
      assert (address < 32'd1024) else begin
        errors++;
        $display("** Error: address = %h, outside the 1 KiB memory", address);
      end
      if (read) begin
        readdata = dut_mem[address[9:2]];
      end else begin
        assert (expected.size() > 0) else begin
          errors++;
          $display("store to %h arrived after the last expected store", address);
        end
        if (expected.size() > 0) begin
          exp_st = expected.pop_front();
          mask   = lane_mask(exp_st.be);
          assert (address === exp_st.addr) else begin
            errors++;
            $display("** Error: address = %h, expected %h", address, exp_st.addr);
          end
          assert (byteenable === exp_st.be) else begin
            errors++;
            $display("** Error: byteenable = %h, expected %h", byteenable, exp_st.be);
          end
          assert ((writedata & mask) === exp_st.data) else begin
            errors++;
            $display("** Error: writedata = %h, expected %h (lanes %h)",
                     writedata, exp_st.data, exp_st.be);
          end
        end
        dut_mem[address[9:2]] = merge_lanes(dut_mem[address[9:2]], writedata, byteenable);
      end
    end
  endtask

  task automatic run_program(input int num);
    reset_n     = 1'b0;
    waitrequest = 1'b1;
    readdata    = '0;
    expected.delete();
    build_program();
    run_model();
    repeat (16) begin
      @(negedge clk);
      assert (!read && !write && !halt) else begin
        errors++;
        $display("read, write or halt high during reset");
      end
    end
    reset_n = 1'b1;
    @(negedge clk);
    assert (read === 1'b1 && write === 1'b0) else begin
      errors++;
      $display("first fetch did not start in the first cycle after reset");
    end
    assert (address === 32'h0) else begin
      errors++;
      $display("** Error: address = %h, expected 00000000", address);
    end
    while (!halt) begin
      serve_bus();
      @(negedge clk);
    end
    assert (expected.size() == 0) else begin
      errors++;
      $display("%0d expected stores never reached the bus", expected.size());
    end
    waitrequest = 1'b0;
    repeat (8) begin
      assert (!read && !write && halt) else begin
        errors++;
        $display("bus activity or a halt drop after halt");
      end
      @(negedge clk);
    end
    $display("program %0d: %0d instructions, halted at %0t", num, executed, $time);
  endtask

  initial begin
    void'($urandom(42604));
    reset_n     = 1'b0;
    waitrequest = 1'b1;
    readdata    = '0;
    errors      = 0;
    for (int p = 0; p < n_programs; p++) begin
      run_program(p);
    end
    $display("%0d testbench errors, %0d protocol assertion failures",
             errors, dut.u_assert.failures);
    if (errors == 0 && dut.u_assert.failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout, the programs did not finish within %0d ns", watchdog_ns);
    $display("%0d testbench errors, %0d protocol assertion failures",
             errors, dut.u_assert.failures);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
source/cpu_pkg.sv
source/cpu_alu.sv
source/int_mul.sv
source/reg_file.sv
source/cpu_control.sv
source/cpu_core.sv
tb/cpu_assert.sv
tb/tb_cpu.sv
